//--- src/husky_pkg.sv
package husky_pkg;

   // register bus widths
   localparam int REG_ADDR_W = 8;
   localparam int REG_DATA_W = 8;

   // register map of the USB side
   typedef enum logic [REG_ADDR_W-1:0] {
      REG_ID          = 8'h00, // read-only board id
      REG_TARGET_CTRL = 8'h01,
      REG_OUTPUT_EN   = 8'h02,
      REG_OUTPUT_VAL  = 8'h03,
      REG_ERROR       = 8'h04, // sticky flags, write 1 to clear
      REG_LED         = 8'h05
   } reg_addr_e;

   localparam logic [REG_DATA_W-1:0] BOARD_ID          = 8'h5A;
   localparam logic [REG_DATA_W-1:0] TARGET_CTRL_RESET = 8'h01; // target unpowered

   // REG_TARGET_CTRL bits
   localparam int CTRL_PWR_OFF_BIT = 0;
   localparam int CTRL_AVRPROG_BIT = 1;

   // REG_OUTPUT_EN / REG_OUTPUT_VAL bits
   localparam int OUT_PIN_W    = 3;
   localparam int PIN_NRST_BIT = 0;
   localparam int PIN_PDID_BIT = 1;
   localparam int PIN_PDIC_BIT = 2;

   // error sources: fifo, xadc, trace
   localparam int ERR_W = 3;

   // REG_LED bit
   localparam int LED_GLITCH_BIT = 0;

   // red LED flash pattern
   localparam int FLASH_HALF_PERIOD = 8;
   localparam int FLASH_CNT_W       = 3;

   // decoded register access, one cycle per strobe
   typedef struct packed {
      logic [REG_ADDR_W-1:0] addr;
      logic [REG_DATA_W-1:0] wdata;
      logic                  write; // one-cycle write pulse
      logic                  read;  // one-cycle read pulse
   } reg_bus_t;

   // split tristate pin
   typedef struct packed {
      logic value;
      logic enable;
   } pin_drive_t;

   typedef struct packed {
      pin_drive_t nrst;
      pin_drive_t pdid;
      pin_drive_t pdic;
      pin_drive_t mosi;
      pin_drive_t sck;
   } target_pins_t;

endpackage

//--- src/usb_reg_bus.sv
module usb_reg_bus
   import husky_pkg::*;
(
   input  logic                  clk_usb_buf,
   input  logic                  arst_n_i,

   input  logic [REG_ADDR_W-1:0] usb_addr_i,
   input  logic [REG_DATA_W-1:0] usb_data_i,
   input  logic                  usb_rdn_i,
   input  logic                  usb_wrn_i,
   input  logic                  usb_cen_i,
   input  logic                  usb_alen_i,

   input  logic [REG_DATA_W-1:0] rd_data_target_i,
   input  logic [REG_DATA_W-1:0] rd_data_status_i,

   output reg_bus_t              reg_bus_o,
   output logic [REG_DATA_W-1:0] usb_data_o,
   output logic                  usb_data_oe_o
);

   logic [REG_ADDR_W-1:0] addr_q;
   logic                  wrn_q;
   logic                  wrn_prev_q;
   logic                  rdn_q;
   logic                  rdn_prev_q;
   logic                  cen_q;

   logic                  wr_fall;
   logic                  rd_fall;

   logic                  wr_pulse_q;
   logic                  rd_pulse_q;
   logic [REG_DATA_W-1:0] wdata_q;

   logic [REG_DATA_W-1:0] rd_data_id;
   logic [REG_DATA_W-1:0] rd_data_q;

   // address latch and strobe sampling
   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         addr_q     <= '0;
         wrn_q      <= 1'b1;
         wrn_prev_q <= 1'b1;
         rdn_q      <= 1'b1;
         rdn_prev_q <= 1'b1;
         cen_q      <= 1'b1;
      end else begin
         if (!usb_alen_i)
            addr_q <= usb_addr_i; // transparent while alen low
         wrn_q      <= usb_wrn_i;
         wrn_prev_q <= wrn_q;
         rdn_q      <= usb_rdn_i;
         rdn_prev_q <= rdn_q;
         cen_q      <= usb_cen_i;
      end
   end

   // falling edges of the sampled strobes, chip enable qualified
   assign wr_fall = wrn_prev_q & ~wrn_q & ~cen_q;
   assign rd_fall = rdn_prev_q & ~rdn_q & ~cen_q;

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_pulse_q <= 1'b0;
         rd_pulse_q <= 1'b0;
      end else begin
         wr_pulse_q <= wr_fall;
         rd_pulse_q <= rd_fall;
      end
   end

   // write data captured alongside the pulse
   always_ff @(posedge clk_usb_buf) begin
      if (wr_fall)
         wdata_q <= usb_data_i;
   end

   assign reg_bus_o = '{
      addr:  addr_q,
      wdata: wdata_q,
      write: wr_pulse_q,
      read:  rd_pulse_q
   };

   // the id register lives here
   assign rd_data_id = (addr_q == REG_ID) ? BOARD_ID : '0;

   // blocks return zero outside their own addresses, so a plain OR
   always_ff @(posedge clk_usb_buf) begin
      rd_data_q <= rd_data_id | rd_data_target_i | rd_data_status_i;
   end

   assign usb_data_o    = rd_data_q;
   assign usb_data_oe_o = ~cen_q & ~rdn_q; // drive bus during a read

endmodule

//--- src/target_io_ctrl.sv
module target_io_ctrl
   import husky_pkg::*;
(
   input  logic                  clk_usb_buf,
   input  logic                  arst_n_i,

   input  reg_bus_t              reg_bus_i,

   input  logic                  sam_mosi_i,
   input  logic                  sam_spck_i,
   input  logic                  target_miso_i,
   input  logic                  usb_spare0_i,

   output logic [REG_DATA_W-1:0] rd_data_o,
   output target_pins_t          pins_o,
   output logic                  sam_miso_o,
   output logic                  sam_miso_oe_o,
   output logic                  target_poweron_o
);

   logic                 pwr_off_q;
   logic                 avrprog_q;
   logic [OUT_PIN_W-1:0] out_en_q;
   logic [OUT_PIN_W-1:0] out_val_q;

   logic                 wr_ctrl;
   logic                 wr_en;
   logic                 wr_val;
   logic                 powered;

   assign wr_ctrl = reg_bus_i.write && (reg_bus_i.addr == REG_TARGET_CTRL);
   assign wr_en   = reg_bus_i.write && (reg_bus_i.addr == REG_OUTPUT_EN);
   assign wr_val  = reg_bus_i.write && (reg_bus_i.addr == REG_OUTPUT_VAL);

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pwr_off_q <= TARGET_CTRL_RESET[CTRL_PWR_OFF_BIT];
         avrprog_q <= TARGET_CTRL_RESET[CTRL_AVRPROG_BIT];
         out_en_q  <= '0;
         out_val_q <= '0;
      end else begin
         if (wr_ctrl) begin
            pwr_off_q <= reg_bus_i.wdata[CTRL_PWR_OFF_BIT];
            avrprog_q <= reg_bus_i.wdata[CTRL_AVRPROG_BIT];
         end
         if (wr_en)
            out_en_q <= reg_bus_i.wdata[OUT_PIN_W-1:0];
         if (wr_val)
            out_val_q <= reg_bus_i.wdata[OUT_PIN_W-1:0];
      end
   end

   // register readback, zero outside our addresses
   always_comb begin
      rd_data_o = '0;
      case (reg_bus_i.addr)
         REG_TARGET_CTRL: begin
            rd_data_o[CTRL_PWR_OFF_BIT] = pwr_off_q;
            rd_data_o[CTRL_AVRPROG_BIT] = avrprog_q;
         end
         REG_OUTPUT_EN:  rd_data_o[OUT_PIN_W-1:0] = out_en_q;
         REG_OUTPUT_VAL: rd_data_o[OUT_PIN_W-1:0] = out_val_q;
         default:        rd_data_o = '0;
      endcase
   end

   assign powered          = ~pwr_off_q;
   assign target_poweron_o = powered;

   // target side pins, all floating while the target is unpowered
   always_comb begin
      // avr programming takes nrst over from the register value
      pins_o.nrst.enable = powered & (avrprog_q | out_en_q[PIN_NRST_BIT]);
      pins_o.nrst.value  = avrprog_q ? usb_spare0_i : out_val_q[PIN_NRST_BIT];

      pins_o.pdid.enable = powered & out_en_q[PIN_PDID_BIT];
      pins_o.pdid.value  = out_val_q[PIN_PDID_BIT];

      pins_o.pdic.enable = powered & out_en_q[PIN_PDIC_BIT];
      pins_o.pdic.value  = out_val_q[PIN_PDIC_BIT];

      pins_o.mosi.enable = powered & avrprog_q; // sam spi passthrough
      pins_o.mosi.value  = sam_mosi_i;

      pins_o.sck.enable  = powered & avrprog_q;
      pins_o.sck.value   = sam_spck_i;
   end

   // miso back to the sam, independent of target power
   assign sam_miso_o    = target_miso_i;
   assign sam_miso_oe_o = avrprog_q;

endmodule

//--- src/status_led.sv
module status_led
   import husky_pkg::*;
(
   input  logic                  clk_usb_buf,
   input  logic                  arst_n_i,

   input  reg_bus_t              reg_bus_i,
   input  logic [ERR_W-1:0]      err_i,
   input  logic                  pll_status_i,

   output logic [REG_DATA_W-1:0] rd_data_o,
   output logic                  led_adc_o,
   output logic                  led_glitch_o
);

   logic [ERR_W-1:0]       err_flags_q;
   logic [ERR_W-1:0]       clr_mask;
   logic                   led_glitch_q;
   logic [FLASH_CNT_W-1:0] flash_cnt_q;
   logic                   flash_q;
   logic                   error_any;

   // write-1-to-clear mask
   assign clr_mask = (reg_bus_i.write && (reg_bus_i.addr == REG_ERROR)) ?
                     reg_bus_i.wdata[ERR_W-1:0] : '0;

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         err_flags_q  <= '0;
         led_glitch_q <= 1'b0;
      end else begin
         err_flags_q <= (err_flags_q & ~clr_mask) | err_i; // set beats clear
         if (reg_bus_i.write && (reg_bus_i.addr == REG_LED))
            led_glitch_q <= reg_bus_i.wdata[LED_GLITCH_BIT];
      end
   end

   // free-running flash pattern
   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         flash_cnt_q <= '0;
         flash_q     <= 1'b0;
      end else if (flash_cnt_q == FLASH_CNT_W'(FLASH_HALF_PERIOD - 1)) begin
         flash_cnt_q <= '0;
         flash_q     <= ~flash_q;
      end else begin
         flash_cnt_q <= flash_cnt_q + 1'b1;
      end
   end

   always_comb begin
      rd_data_o = '0;
      case (reg_bus_i.addr)
         REG_ERROR: rd_data_o[ERR_W-1:0]     = err_flags_q;
         REG_LED:   rd_data_o[LED_GLITCH_BIT] = led_glitch_q;
         default:   rd_data_o = '0;
      endcase
   end

   assign error_any = |err_flags_q;

   // both red LEDs flash while any error is pending
   assign led_adc_o    = error_any ? flash_q : ~pll_status_i;
   assign led_glitch_o = error_any ? flash_q : led_glitch_q;

endmodule

//--- src/husky_top.sv
module husky_top
   import husky_pkg::*;
(
   input  logic                  clk_usb_buf,
   input  logic                  arst_n_i,

   // usb register bus
   input  logic [REG_ADDR_W-1:0] usb_addr_i,
   input  logic [REG_DATA_W-1:0] usb_data_i,
   input  logic                  usb_rdn_i,
   input  logic                  usb_wrn_i,
   input  logic                  usb_cen_i,
   input  logic                  usb_alen_i,
   output logic [REG_DATA_W-1:0] usb_data_o,
   output logic                  usb_data_oe_o,

   // avr programming lines
   input  logic                  sam_mosi_i,
   input  logic                  sam_spck_i,
   input  logic                  target_miso_i,
   input  logic                  usb_spare0_i,  // nrst source in avr mode
   output logic                  sam_miso_o,
   output logic                  sam_miso_oe_o,

   output target_pins_t          target_pins_o,
   output logic                  target_poweron_o,

   // error sources and leds
   input  logic [ERR_W-1:0]      err_i,
   input  logic                  pll_status_i,
   output logic                  led_adc_o,
   output logic                  led_glitch_o
);

   reg_bus_t              reg_bus;
   logic [REG_DATA_W-1:0] rd_data_target;
   logic [REG_DATA_W-1:0] rd_data_status;

   usb_reg_bus usb_reg_bus_inst (
      .clk_usb_buf      (clk_usb_buf),
      .arst_n_i         (arst_n_i),
      .usb_addr_i       (usb_addr_i),
      .usb_data_i       (usb_data_i),
      .usb_rdn_i        (usb_rdn_i),
      .usb_wrn_i        (usb_wrn_i),
      .usb_cen_i        (usb_cen_i),
      .usb_alen_i       (usb_alen_i),
      .rd_data_target_i (rd_data_target),
      .rd_data_status_i (rd_data_status),
      .reg_bus_o        (reg_bus),
      .usb_data_o       (usb_data_o),
      .usb_data_oe_o    (usb_data_oe_o)
   );

   target_io_ctrl target_io_ctrl_inst (
      .clk_usb_buf      (clk_usb_buf),
      .arst_n_i         (arst_n_i),
      .reg_bus_i        (reg_bus),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .usb_spare0_i     (usb_spare0_i),
      .rd_data_o        (rd_data_target),
      .pins_o           (target_pins_o),
      .sam_miso_o       (sam_miso_o),
      .sam_miso_oe_o    (sam_miso_oe_o),
      .target_poweron_o (target_poweron_o)
   );

   status_led status_led_inst (
      .clk_usb_buf      (clk_usb_buf),
      .arst_n_i         (arst_n_i),
      .reg_bus_i        (reg_bus),
      .err_i            (err_i),
      .pll_status_i     (pll_status_i),
      .rd_data_o        (rd_data_status),
      .led_adc_o        (led_adc_o),
      .led_glitch_o     (led_glitch_o)
   );

endmodule

//--- testbench/husky_top_properties.sv
module husky_top_properties
   import husky_pkg::*;
(
   input logic             clk_usb_buf,
   input logic             arst_n_i,
   input logic             usb_cen_i,
   input logic             usb_data_oe_o,
   input target_pins_t     target_pins_o,
   input logic             target_poweron_o,
   input logic [ERR_W-1:0] err_i,
   input logic             led_adc_o,
   input logic             led_glitch_o
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_count = 0;
   logic [4:0]  enables;

   assign enables = {target_pins_o.nrst.enable, target_pins_o.pdid.enable,
                     target_pins_o.pdic.enable, target_pins_o.mosi.enable,
                     target_pins_o.sck.enable};

   // pins float while the target is unpowered
   pins_unpowered: assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      !target_poweron_o |-> enables == 5'b0)
      else begin
         $error("pin enable set while target power is off");
         fail_count++;
      end

   data_oe_cen: assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      usb_data_oe_o |-> !$past(usb_cen_i))
      else begin
         $error("usb data driven without chip enable on the previous cycle");
         fail_count++;
      end

   // both leds carry the flash pattern once a flag is set
   err_flash: assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      |err_i |=> led_adc_o == led_glitch_o)
      else begin
         $error("leds not flashing together after an error pulse");
         fail_count++;
      end

endmodule

bind husky_top husky_top_properties props_inst (
   .clk_usb_buf      (clk_usb_buf),
   .arst_n_i         (arst_n_i),
   .usb_cen_i        (usb_cen_i),
   .usb_data_oe_o    (usb_data_oe_o),
   .target_pins_o    (target_pins_o),
   .target_poweron_o (target_poweron_o),
   .err_i            (err_i),
   .led_adc_o        (led_adc_o),
   .led_glitch_o     (led_glitch_o)
);

//--- testbench/tb_husky_top.sv
module tb_husky_top
   import husky_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD  = 4;
   localparam int TEST_CYCLES = 380; // summed length of all tests in cycles

   logic                  clk_usb_buf = 1'b0;
   logic                  arst_n;
   logic [REG_ADDR_W-1:0] usb_addr;
   logic [REG_DATA_W-1:0] usb_wdata;
   logic [REG_DATA_W-1:0] usb_rdata;
   logic                  usb_rdn, usb_wrn, usb_cen, usb_alen;
   logic                  usb_data_oe;
   logic                  sam_mosi, sam_spck, target_miso, usb_spare0;
   logic                  sam_miso, sam_miso_oe, target_poweron;
   logic [ERR_W-1:0]      err;
   logic                  pll_status, led_adc, led_glitch;
   target_pins_t          target_pins;

   int test_errors;
   int tests_passed;
   int tests_failed;

   husky_top husky_top_inst (
      .clk_usb_buf      (clk_usb_buf),
      .arst_n_i         (arst_n),
      .usb_addr_i       (usb_addr),
      .usb_data_i       (usb_wdata),
      .usb_rdn_i        (usb_rdn),
      .usb_wrn_i        (usb_wrn),
      .usb_cen_i        (usb_cen),
      .usb_alen_i       (usb_alen),
      .usb_data_o       (usb_rdata),
      .usb_data_oe_o    (usb_data_oe),
      .sam_mosi_i       (sam_mosi),
      .sam_spck_i       (sam_spck),
      .target_miso_i    (target_miso),
      .usb_spare0_i     (usb_spare0),
      .sam_miso_o       (sam_miso),
      .sam_miso_oe_o    (sam_miso_oe),
      .target_pins_o    (target_pins),
      .target_poweron_o (target_poweron),
      .err_i            (err),
      .pll_status_i     (pll_status),
      .led_adc_o        (led_adc),
      .led_glitch_o     (led_glitch)
   );

   always #(CLK_PERIOD / 2) clk_usb_buf = ~clk_usb_buf;

   // watchdog at twice the expected run length
   initial begin
      #(TEST_CYCLES * 2 * CLK_PERIOD);
      $display("watchdog expired, the tests did not finish in time");
      $display("SOME TESTS FAILED");
      $finish;
   end

   task automatic check_hex(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp) else begin
         $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         test_errors++;
      end
   endtask

   function automatic logic [4:0] pin_enables(input target_pins_t p);
      return {p.nrst.enable, p.pdid.enable, p.pdic.enable, p.mosi.enable, p.sck.enable};
   endfunction

   task automatic finish_test(input string name);
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %s: pass", name);
      end else begin
         tests_failed++;
         $display("test %s: fail, %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   // address phase, then wrn low for four cycles
   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      @(posedge clk_usb_buf);
      usb_addr <= addr;
      usb_alen <= 1'b0;
      @(posedge clk_usb_buf);
      usb_alen  <= 1'b1;
      usb_cen   <= 1'b0;
      usb_wrn   <= 1'b0;
      usb_wdata <= data;
      repeat (4) @(posedge clk_usb_buf);
      usb_wrn <= 1'b1;
      usb_cen <= 1'b1;
      @(posedge clk_usb_buf); // register has taken the write by now
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
      @(posedge clk_usb_buf);
      usb_addr <= addr;
      usb_alen <= 1'b0;
      @(posedge clk_usb_buf);
      usb_alen <= 1'b1;
      usb_cen  <= 1'b0;
      usb_rdn  <= 1'b0;
      repeat (4) @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);
      data = usb_rdata;
      assert (usb_data_oe === 1'b1) else begin
         $display("usb_data_oe_o was low in the middle of a read");
         test_errors++;
      end
      @(posedge clk_usb_buf);
      usb_rdn <= 1'b1;
      usb_cen <= 1'b1;
      @(posedge clk_usb_buf);
   endtask

   task automatic expect_reg(input string name, input logic [7:0] addr, input logic [7:0] exp);
      logic [7:0] data;
      bus_read(addr, data);
      check_hex(name, data, exp);
   endtask

   initial begin
      logic [31:0] r;
      logic [7:0]  v;
      logic        prev;
      int          n;

      void'($urandom(32'h0f65bbb1));
      test_errors  = 0;
      tests_passed = 0;
      tests_failed = 0;
      arst_n       = 1'b0;
      usb_addr     = '0;
      usb_wdata    = '0;
      usb_rdn      = 1'b1;
      usb_wrn      = 1'b1;
      usb_cen      = 1'b1;
      usb_alen     = 1'b1;
      sam_mosi     = 1'b0;
      sam_spck     = 1'b0;
      target_miso  = 1'b0;
      usb_spare0   = 1'b0;
      err          = '0;
      pll_status   = 1'b1; // normal adc led level is 0
      repeat (16) @(posedge clk_usb_buf);
      arst_n <= 1'b1;

      @(negedge clk_usb_buf);
      check_hex("pin enables", 8'(pin_enables(target_pins)), 8'h00);
      check_hex("sam_miso_oe_o", 8'(sam_miso_oe), 8'h00);
      check_hex("target_poweron_o", 8'(target_poweron), 8'h00);
      check_hex("usb_data_oe_o", 8'(usb_data_oe), 8'h00);
      expect_reg("REG_ID", REG_ID, 8'h5A);
      expect_reg("REG_ERROR", REG_ERROR, 8'h00);
      expect_reg("REG_TARGET_CTRL", REG_TARGET_CTRL, 8'h01);
      finish_test("reset_state");

      repeat (4) begin
         r = $urandom();
         bus_write(REG_OUTPUT_EN, r[7:0]);
         bus_write(REG_OUTPUT_VAL, r[15:8]);
         bus_write(REG_LED, r[23:16]);
         expect_reg("REG_OUTPUT_EN", REG_OUTPUT_EN, r[7:0] & 8'h07);
         expect_reg("REG_OUTPUT_VAL", REG_OUTPUT_VAL, r[15:8] & 8'h07);
         expect_reg("REG_LED", REG_LED, r[23:16] & 8'h01);
      end
      finish_test("register_readback");

      bus_write(REG_OUTPUT_EN, 8'h07);
      bus_write(REG_TARGET_CTRL, 8'h00); // power on without avr programming
      repeat (4) begin
         v = 8'($urandom());
         bus_write(REG_OUTPUT_VAL, v);
         @(negedge clk_usb_buf);
         check_hex("target_poweron_o", 8'(target_poweron), 8'h01);
         check_hex("pin enables", 8'(pin_enables(target_pins)), 8'h1c);
         check_hex("nrst value", 8'(target_pins.nrst.value), 8'(v[0]));
         check_hex("pdid value", 8'(target_pins.pdid.value), 8'(v[1]));
         check_hex("pdic value", 8'(target_pins.pdic.value), 8'(v[2]));
      end
      bus_write(REG_TARGET_CTRL, 8'h01);
      @(negedge clk_usb_buf);
      check_hex("pin enables", 8'(pin_enables(target_pins)), 8'h00);
      check_hex("target_poweron_o", 8'(target_poweron), 8'h00);
      finish_test("output_pins");

      bus_write(REG_OUTPUT_EN, 8'h00);
      bus_write(REG_OUTPUT_VAL, 8'h00);
      bus_write(REG_TARGET_CTRL, 8'h02); // power on with avr programming
      repeat (8) begin
         @(posedge clk_usb_buf);
         r = $urandom();
         sam_mosi    <= r[0];
         sam_spck    <= r[1];
         usb_spare0  <= r[2];
         target_miso <= r[3];
         @(negedge clk_usb_buf);
         check_hex("pin enables", 8'(pin_enables(target_pins)), 8'h13);
         check_hex("mosi value", 8'(target_pins.mosi.value), 8'(r[0]));
         check_hex("sck value", 8'(target_pins.sck.value), 8'(r[1]));
         check_hex("nrst value", 8'(target_pins.nrst.value), 8'(r[2]));
         check_hex("sam_miso_o", 8'(sam_miso), 8'(r[3]));
         check_hex("sam_miso_oe_o", 8'(sam_miso_oe), 8'h01);
      end
      bus_write(REG_TARGET_CTRL, 8'h03); // unpowered but miso still driven
      @(negedge clk_usb_buf);
      check_hex("pin enables", 8'(pin_enables(target_pins)), 8'h00);
      check_hex("sam_miso_oe_o", 8'(sam_miso_oe), 8'h01);
      bus_write(REG_TARGET_CTRL, 8'h01);
      finish_test("avr_programming");

      bus_write(REG_LED, 8'h01);
      @(negedge clk_usb_buf);
      check_hex("led_adc_o", 8'(led_adc), 8'h00);
      check_hex("led_glitch_o", 8'(led_glitch), 8'h01);
      @(posedge clk_usb_buf);
      err <= 3'b010; // one-cycle xadc error
      @(posedge clk_usb_buf);
      err <= 3'b000;
      @(negedge clk_usb_buf);
      for (int k = 0; k < 2; k++) begin
         // first pass syncs to a toggle and the second one measures
         prev = led_adc;
         n    = 0;
         while (led_adc == prev && n < 2 * FLASH_HALF_PERIOD) begin
            @(negedge clk_usb_buf);
            n++;
         end
      end
      check_hex("flash half period", 8'(n), 8'd8);
      check_hex("led_glitch_o", 8'(led_glitch), prev ? 8'h00 : 8'h01);
      expect_reg("REG_ERROR", REG_ERROR, 8'h02);
      bus_write(REG_ERROR, 8'h02);
      expect_reg("REG_ERROR", REG_ERROR, 8'h00);
      @(negedge clk_usb_buf);
      check_hex("led_adc_o", 8'(led_adc), 8'h00);
      check_hex("led_glitch_o", 8'(led_glitch), 8'h01);
      finish_test("error_led");

      $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
               tests_passed, tests_failed, husky_top_inst.props_inst.fail_count);
      if (tests_failed == 0 && husky_top_inst.props_inst.fail_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
src/husky_pkg.sv
src/usb_reg_bus.sv
src/target_io_ctrl.sv
src/status_led.sv
src/husky_top.sv
testbench/husky_top_properties.sv
testbench/tb_husky_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the husky_top testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_husky_top -f files.f

output=$(./obj_dir/Vtb_husky_top +verilator+error+limit+100 || true)
echo "$output"

if grep -qx "ALL TESTS PASSED" <<< "$output"; then
   exit 0
fi
exit 1
